/* all.f */
irq_pkg.sv
irq_line_capture.sv
irq_priority_select.sv
irq_int_controller.sv
irq_trap_sequencer.sv
irq_subsystem_top.sv
tb_irq_subsystem.sv

/* irq_int_controller.sv */
// stage 3 of the interrupt path: gates the pending interrupt with the global
// enables and raises a level request towards the core controller
`timescale 1ns/1ps

module irq_int_controller
#(
  // 0: machine enable only, 1: privilege aware gating
  parameter bit SECURE_EN = 1'b0
)
(
  input  logic                clk,
  input  logic                rst_n,

  // winner from the select stage
  input  logic                irq_pending_i,
  input  logic                irq_sec_i,
  input  irq_pkg::irq_id_t    irq_id_i,

  // global enables and current privilege
  input  logic                m_ie_i,
  input  logic                u_ie_i,
  input  irq_pkg::priv_lvl_t  priv_lvl_i,

  // strobes from the trap sequencer
  input  logic                ctrl_ack_i,
  input  logic                ctrl_kill_i,

  // request towards the trap sequencer
  output logic                irq_req_ctrl_o,
  output logic                irq_sec_ctrl_o,
  output irq_pkg::irq_id_t    irq_id_ctrl_o
);

  import irq_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PENDING,
    ST_DONE
  } ctrl_state_t;

  ctrl_state_t state_q;
  logic        irq_enable;
  irq_id_t     irq_id_q;
  logic        irq_sec_q;

  //////////////////////////////////////////////////////////////////////
  // enable gating
  //////////////////////////////////////////////////////////////////////

  if (SECURE_EN)
  begin : g_secure_gate
    // user level takes an interrupt when u_ie is set or the line is secure
    // machine level only looks at m_ie
    assign irq_enable = ((u_ie_i | irq_sec_i) & (priv_lvl_i == PRIV_LVL_U))
                      | (m_ie_i & (priv_lvl_i == PRIV_LVL_M));
  end
  else
  begin : g_plain_gate
    // privilege ignored
    assign irq_enable = m_ie_i;
  end

  //////////////////////////////////////////////////////////////////////
  // request fsm
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= ST_IDLE;
      irq_id_q  <= '0;
      irq_sec_q <= 1'b0;
    end
    else
    begin
      unique case (state_q)
        ST_IDLE:
        begin
          // id and secure bit frozen here for the whole round
          if (irq_enable && irq_pending_i)
          begin
            state_q   <= ST_PENDING;
            irq_id_q  <= irq_id_i;
            irq_sec_q <= irq_sec_i;
          end
        end
        ST_PENDING:
        begin
          // request stays up until the sequencer answers
          // the sequencer never sends both strobes at once
          if (ctrl_ack_i)
          begin
            state_q <= ST_DONE;
          end
          else if (ctrl_kill_i)
          begin
            // back to idle so the lines are sampled again
            state_q <= ST_IDLE;
          end
        end
        ST_DONE:
        begin
          // trap taken, secure attribute no longer valid
          irq_sec_q <= 1'b0;
          state_q   <= ST_IDLE;
        end
        default:
        begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  assign irq_req_ctrl_o = (state_q == ST_PENDING);
  assign irq_sec_ctrl_o = irq_sec_q;
  assign irq_id_ctrl_o  = irq_id_q;

endmodule

/* irq_line_capture.sv */
// stage 1 of the interrupt path that brings the raw interrupt levels into clk
// and applies the per-line enable mask
`timescale 1ns/1ps

module irq_line_capture
(
  input  logic                clk,
  input  logic                rst_n,

  // raw asynchronous levels from the sources
  input  irq_pkg::irq_lines_t irq_i,
  // per-line enable, one bit per source
  input  irq_pkg::irq_lines_t irq_en_i,

  // synchronized and masked levels towards the select stage
  output irq_pkg::irq_lines_t masked_lines_o
);

  import irq_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // synchronizer
  //////////////////////////////////////////////////////////////////////

  // first flop may go metastable
  irq_lines_t sync_q1;
  // second flop gives a settled level
  irq_lines_t sync_q2;

  // two flops per line
  // a change on irq_i is visible on sync_q2 two edges later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // no line is seen as pending out of reset
      sync_q1 <= '0;
      sync_q2 <= '0;
    end
    else
    begin
      sync_q1 <= irq_i;
      sync_q2 <= sync_q1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // masking
  //////////////////////////////////////////////////////////////////////

  // mask applied right behind the second flop
  // the stage latency stays at two cycles
  irq_lines_t masked_lines;

  always_comb
  begin
    masked_lines = sync_q2 & irq_en_i;
  end

  // lines stay level sensitive
  // a source that drops its line also drops it here as nothing is latched
  assign masked_lines_o = masked_lines;

endmodule

/* irq_pkg.sv */
// shared types and constants of the interrupt path
// imported by every stage of the subsystem and by the testbench
package irq_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  // number of level-triggered interrupt lines entering the subsystem
  localparam int unsigned IRQ_NUM_LINES = 32;

  // bits needed to index one line
  localparam int unsigned IRQ_IDX_W = $clog2(IRQ_NUM_LINES);

  // id width kept at 6 bits to match the core controller interface
  localparam int unsigned IRQ_ID_W = 6;

  // code address width
  localparam int unsigned ADDR_W = 32;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // one bit per interrupt line
  typedef logic [IRQ_NUM_LINES-1:0] irq_lines_t;

  // interrupt number, only 0 to 31 ever used
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // vector base and trap vector
  typedef logic [ADDR_W-1:0] addr_t;

  // privilege level of the hart
  // encoding follows the usual riscv mpp values
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  //////////////////////////////////////////////////////////////////////
  // vector table
  //////////////////////////////////////////////////////////////////////

  // byte spacing between two vector entries (one jump instruction)
  localparam addr_t IRQ_VEC_STRIDE = addr_t'(4);

endpackage

/* irq_priority_select.sv */
// stage 2 of the interrupt path: picks the highest-numbered masked line
// and looks up its secure bit, all registered for one cycle
`timescale 1ns/1ps

module irq_priority_select
(
  input  logic                clk,
  input  logic                rst_n,

  // synchronized and masked lines from the capture stage
  input  irq_pkg::irq_lines_t masked_lines_i,
  // secure attribute of every line
  input  irq_pkg::irq_lines_t irq_sec_mask_i,

  // towards the interrupt controller, driven every cycle
  output logic                irq_pending_o,
  output irq_pkg::irq_id_t    irq_id_o,
  output logic                irq_sec_o
);

  import irq_pkg::*;

  // combinational winner
  logic    win_pending;
  irq_id_t win_id;
  logic    win_sec;

  // registered result
  logic    pending_q;
  irq_id_t id_q;
  logic    sec_q;

  //////////////////////////////////////////////////////////////////////
  // highest id wins
  //////////////////////////////////////////////////////////////////////

  // scan upwards so the last set line found is the highest one
  always_comb
  begin
    win_pending = 1'b0;
    win_id      = '0;
    for (int i = 0; i < IRQ_NUM_LINES; i++)
    begin
      if (masked_lines_i[i])
      begin
        win_pending = 1'b1;
        win_id      = irq_id_t'(i);
      end
    end
  end

  // secure bit of the winner
  // forced to zero when nothing is pending
  assign win_sec = win_pending & irq_sec_mask_i[win_id[IRQ_IDX_W-1:0]];

  // one register stage
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending_q <= 1'b0;
      id_q      <= '0;
      sec_q     <= 1'b0;
    end
    else
    begin
      pending_q <= win_pending;
      id_q      <= win_id;
      sec_q     <= win_sec;
    end
  end

  assign irq_pending_o = pending_q;
  assign irq_id_o      = id_q;
  assign irq_sec_o     = sec_q;

endmodule

/* irq_subsystem_top.sv */
// interrupt path of the core: capture, select, controller and trap sequencer
// chained in that order, SECURE_EN picks the enable gating
`timescale 1ns/1ps

module irq_subsystem_top
#(
  // 0: machine enable only, 1: privilege aware gating
  parameter bit SECURE_EN = 1'b0
)
(
  input  logic                clk,
  input  logic                rst_n,

  // interrupt sources and their attributes
  input  irq_pkg::irq_lines_t irq_i,
  input  irq_pkg::irq_lines_t irq_en_i,
  input  irq_pkg::irq_lines_t irq_sec_mask_i,

  // csr state
  input  logic                m_ie_i,
  input  logic                u_ie_i,
  input  irq_pkg::priv_lvl_t  priv_lvl_i,
  input  irq_pkg::addr_t      mtvec_i,

  // core pipeline
  input  logic                core_ready_i,
  input  logic                flush_i,

  // trap out
  output logic                trap_valid_o,
  output irq_pkg::irq_id_t    trap_id_o,
  output logic                trap_sec_o,
  output irq_pkg::addr_t      trap_vec_o
);

  import irq_pkg::*;

  // capture to select
  irq_lines_t masked_lines;

  // select to controller
  logic       sel_pending;
  irq_id_t    sel_id;
  logic       sel_sec;

  // controller to sequencer
  logic       irq_req;
  irq_id_t    irq_id;
  logic       irq_sec;

  // sequencer back to controller
  logic       ctrl_ack;
  logic       ctrl_kill;

  //////////////////////////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////////////////////////

  irq_line_capture u_capture (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .irq_en_i       (irq_en_i),
    .masked_lines_o (masked_lines)
  );

  irq_priority_select u_select (
    .clk            (clk),
    .rst_n          (rst_n),
    .masked_lines_i (masked_lines),
    .irq_sec_mask_i (irq_sec_mask_i),
    .irq_pending_o  (sel_pending),
    .irq_id_o       (sel_id),
    .irq_sec_o      (sel_sec)
  );

  irq_int_controller #(
    .SECURE_EN (SECURE_EN)
  ) u_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_pending_i  (sel_pending),
    .irq_sec_i      (sel_sec),
    .irq_id_i       (sel_id),
    .m_ie_i         (m_ie_i),
    .u_ie_i         (u_ie_i),
    .priv_lvl_i     (priv_lvl_i),
    .ctrl_ack_i     (ctrl_ack),
    .ctrl_kill_i    (ctrl_kill),
    .irq_req_ctrl_o (irq_req),
    .irq_sec_ctrl_o (irq_sec),
    .irq_id_ctrl_o  (irq_id)
  );

  irq_trap_sequencer u_sequencer (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_req_i      (irq_req),
    .irq_id_i       (irq_id),
    .irq_sec_i      (irq_sec),
    .core_ready_i   (core_ready_i),
    .flush_i        (flush_i),
    .mtvec_i        (mtvec_i),
    .ctrl_ack_o     (ctrl_ack),
    .ctrl_kill_o    (ctrl_kill),
    .trap_valid_o   (trap_valid_o),
    .trap_id_o      (trap_id_o),
    .trap_sec_o     (trap_sec_o),
    .trap_vec_o     (trap_vec_o)
  );

endmodule

/* irq_testdata.txt */
# name irq_i irq_en_i irq_sec_mask_i m_ie u_ie priv mtvec flush_hold ready_hold taken id sec
# lines and mtvec in hex, priv 3 is machine and 0 is user, the rest decimal
prio_single    00000001 ffffffff 00000000 1 0 3 00001000  0  0 1  0 0
prio_pair      00000022 ffffffff 00000000 1 0 3 00001000  0  0 1  5 0
prio_top       80000001 ffffffff 00000000 1 0 3 00002000  0  0 1 31 0
prio_en_top    80008000 7fffffff 00000000 1 0 3 00002000  0  0 1 15 0
prio_many      0f0f0f0f 00ffffff 00000000 1 0 3 0000a000  0  0 1 19 0
prio_sec_win   00000410 ffffffff 00000400 1 0 3 0000a000  0  0 1 10 1
prio_sec_low   00000410 ffffffff 00000010 1 0 3 0000a000  0  0 1 10 0
vec_wrap       80000000 ffffffff 00000000 1 0 3 ffffff00  0  0 1 31 0
mask_all_off   00000100 00000000 00000000 1 0 3 00001000  0  0 0  0 0
mask_line_off  00010000 fffeffff 00000000 1 0 3 00001000  0  0 0  0 0
mie_off        00000004 ffffffff 00000000 0 1 3 00001000  0  0 0  0 0
user_uie       00000040 ffffffff 00000000 0 1 0 00004000  0  0 1  6 0
user_secure    00000040 ffffffff 00000040 0 0 0 00004000  0  0 1  6 1
user_blocked   00000040 ffffffff 00000000 1 0 0 00004000  0  0 0  0 0
user_sec_low   00000041 ffffffff 00000001 1 0 0 00004000  0  0 0  0 0
user_sec_top   20000003 ffffffff 20000000 0 0 0 00004000  0  0 1 29 1
user_uie_sec   00000300 ffffffff 00000200 0 1 0 00004000  0  0 1  9 1
bp_short       00000008 ffffffff 00000000 1 0 3 00003000  0  6 1  3 0
bp_raise       00000100 ffffffff 00000000 1 0 3 00003000  0 20 1  8 0
bp_raise_sec   00001000 0000ffff 00001000 1 0 3 00003000  0 16 1 12 1
bp_user        00000080 ffffffff 00000080 0 0 0 00003000  0 12 1  7 1
flush_short    00000200 ffffffff 00000000 1 0 3 00005000 12  0 1  9 0
flush_long     00400000 ffffffff 00400000 1 0 3 00005000 24  0 1 22 1
flush_user     00000800 ffffffff 00000800 0 0 0 00005000 10  0 1 11 1
flush_ready    00020000 ffffffff 00000000 1 0 3 00005000 10 14 1 17 0

/* irq_trap_sequencer.sv */
// stage 4 of the interrupt path: answers the request with ack or kill as the
// core controller would, and issues a one cycle trap with its vector
`timescale 1ns/1ps

module irq_trap_sequencer
(
  input  logic                clk,
  input  logic                rst_n,

  // request from the interrupt controller
  input  logic                irq_req_i,
  input  irq_pkg::irq_id_t    irq_id_i,
  input  logic                irq_sec_i,

  // pipeline state of the core
  input  logic                core_ready_i,
  input  logic                flush_i,

  // vector table base
  input  irq_pkg::addr_t      mtvec_i,

  // strobes back to the interrupt controller
  output logic                ctrl_ack_o,
  output logic                ctrl_kill_o,

  // trap towards the fetch stage
  output logic                trap_valid_o,
  output irq_pkg::irq_id_t    trap_id_o,
  output logic                trap_sec_o,
  output irq_pkg::addr_t      trap_vec_o
);

  import irq_pkg::*;

  logic    ack;
  logic    kill;
  addr_t   vec_calc;

  logic    trap_valid_q;
  irq_id_t trap_id_q;
  logic    trap_sec_q;
  addr_t   trap_vec_q;

  //////////////////////////////////////////////////////////////////////
  // ack / kill decision
  //////////////////////////////////////////////////////////////////////

  // a flush always wins and withdraws the request
  assign kill = irq_req_i & flush_i;

  // take the interrupt only when the core can accept it
  // flush excluded so ack and kill are never high together
  assign ack = irq_req_i & core_ready_i & ~flush_i;

  // neither strobe means wait with the request held

  assign ctrl_ack_o  = ack;
  assign ctrl_kill_o = kill;

  //////////////////////////////////////////////////////////////////////
  // trap issue
  //////////////////////////////////////////////////////////////////////

  // vectored mode: one entry per interrupt id
  assign vec_calc = mtvec_i + addr_t'(irq_id_i) * IRQ_VEC_STRIDE;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      trap_valid_q <= 1'b0;
      trap_id_q    <= '0;
      trap_sec_q   <= 1'b0;
      trap_vec_q   <= '0;
    end
    else
    begin
      // single pulse the cycle after the ack
      trap_valid_q <= ack;
      if (ack)
      begin
        trap_id_q  <= irq_id_i;
        trap_sec_q <= irq_sec_i;
        trap_vec_q <= vec_calc;
      end
    end
  end

  assign trap_valid_o = trap_valid_q;
  assign trap_id_o    = trap_id_q;
  assign trap_sec_o   = trap_sec_q;
  assign trap_vec_o   = trap_vec_q;

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the interrupt path testbench with verilator and runs it
# the exit status of the run is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f all.f \
  --top-module tb_irq_subsystem -o tb_irq_subsystem &&
./obj_dir/tb_irq_subsystem || exit 1

/* tb_irq_subsystem.sv */
// file-driven testbench of the interrupt path with one test per line of irq_testdata.txt
// each test drives the lines and checks the trap id, secure bit and vector
`timescale 1ns/1ps

module tb_irq_subsystem;

  import irq_pkg::*;

  localparam int MAX_TESTS    = 64;
  localparam int WAIT_CYCLES  = 64;
  localparam int IDLE_CYCLES  = 16;
  // the core flushes while it redirects fetch to the handler
  localparam int DRAIN_CYCLES = 8;
  // cycle of a ready hold at which all enabled lines rise
  localparam int RAISE_CYCLE  = 8;

  logic       clk;
  logic       rst_n;
  irq_lines_t irq_i;
  irq_lines_t irq_en_i;
  irq_lines_t irq_sec_mask_i;
  logic       m_ie_i;
  logic       u_ie_i;
  priv_lvl_t  priv_lvl_i;
  addr_t      mtvec_i;
  logic       core_ready_i;
  logic       flush_i;
  logic       trap_valid_o;
  irq_id_t    trap_id_o;
  logic       trap_sec_o;
  addr_t      trap_vec_o;

  // test table with one entry per data line
  string      name_mem    [MAX_TESTS];
  irq_lines_t irq_mem     [MAX_TESTS];
  irq_lines_t en_mem      [MAX_TESTS];
  irq_lines_t sec_mem     [MAX_TESTS];
  logic       m_ie_mem    [MAX_TESTS];
  logic       u_ie_mem    [MAX_TESTS];
  priv_lvl_t  priv_mem    [MAX_TESTS];
  addr_t      mtvec_mem   [MAX_TESTS];
  int         flush_mem   [MAX_TESTS];
  int         ready_mem   [MAX_TESTS];
  logic       taken_mem   [MAX_TESTS];
  irq_id_t    id_mem      [MAX_TESTS];
  logic       sec_bit_mem [MAX_TESTS];
  int         num_tests;

  int         seed;
  int         cycle_count = 0;
  int         cycle_limit = 0;

  irq_subsystem_top #(
    .SECURE_EN (1'b1)
  ) DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .irq_i          (irq_i),
    .irq_en_i       (irq_en_i),
    .irq_sec_mask_i (irq_sec_mask_i),
    .m_ie_i         (m_ie_i),
    .u_ie_i         (u_ie_i),
    .priv_lvl_i     (priv_lvl_i),
    .mtvec_i        (mtvec_i),
    .core_ready_i   (core_ready_i),
    .flush_i        (flush_i),
    .trap_valid_o   (trap_valid_o),
    .trap_id_o      (trap_id_o),
    .trap_sec_o     (trap_sec_o),
    .trap_vec_o     (trap_vec_o)
  );

  // 8 ns clock
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #4 clk = ~clk;
    end
  end

  // global watchdog whose limit is set once the table is loaded
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit)
    begin
      $display("ERROR: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_id(input string test_name, input irq_id_t exp_id, input irq_id_t act_id);
    if (act_id !== exp_id)
    begin
      abort_run($sformatf("MISMATCH %s trap_id expected %0d actual %0d",
                          test_name, exp_id, act_id));
    end
  endtask

  task automatic check_vec(input string test_name, input addr_t exp_vec, input addr_t act_vec);
    if (act_vec !== exp_vec)
    begin
      abort_run($sformatf("MISMATCH %s trap_vec expected 0x%08h actual 0x%08h",
                          test_name, exp_vec, act_vec));
    end
  endtask

  task automatic check_bit(input string test_name, input string what,
                           input logic exp_bit, input logic act_bit);
    if (act_bit !== exp_bit)
    begin
      abort_run($sformatf("MISMATCH %s %s expected %0b actual %0b",
                          test_name, what, exp_bit, act_bit));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test table
  //////////////////////////////////////////////////////////////////////

  task automatic load_tests();
    int              fd;
    int              fields;
    logic [8*256-1:0] line_buf;
    logic [8*32-1:0] name_buf;
    irq_lines_t      irq_val;
    irq_lines_t      en_val;
    irq_lines_t      sec_mask_val;
    addr_t           mtvec_val;
    int              m_ie_val;
    int              u_ie_val;
    int              priv_val;
    int              flush_val;
    int              ready_val;
    int              taken_val;
    int              id_val;
    int              sec_bit_val;
    num_tests = 0;
    fd = $fopen("irq_testdata.txt", "r");
    if (fd == 0)
    begin
      abort_run("ERROR: cannot open irq_testdata.txt for reading");
    end
    else
    begin
      while (!$feof(fd) && num_tests < MAX_TESTS)
      begin
        line_buf = '0;
        if ($fgets(line_buf, fd) > 0)
        begin
          fields = $sscanf(line_buf, "%s %h %h %h %d %d %d %h %d %d %d %d %d",
                           name_buf, irq_val, en_val, sec_mask_val, m_ie_val, u_ie_val,
                           priv_val, mtvec_val, flush_val, ready_val, taken_val,
                           id_val, sec_bit_val);
          // comment and blank lines stop early
          if (fields == 13)
          begin
            name_mem[num_tests]    = string'(name_buf);
            irq_mem[num_tests]     = irq_val;
            en_mem[num_tests]      = en_val;
            sec_mem[num_tests]     = sec_mask_val;
            m_ie_mem[num_tests]    = (m_ie_val != 0);
            u_ie_mem[num_tests]    = (u_ie_val != 0);
            priv_mem[num_tests]    = priv_lvl_t'(priv_val[1:0]);
            mtvec_mem[num_tests]   = mtvec_val;
            flush_mem[num_tests]   = flush_val;
            ready_mem[num_tests]   = ready_val;
            taken_mem[num_tests]   = (taken_val != 0);
            id_mem[num_tests]      = irq_id_t'(id_val);
            sec_bit_mem[num_tests] = (sec_bit_val != 0);
            num_tests++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one test
  //////////////////////////////////////////////////////////////////////

  // drop all lines, flush for the drain, then idle
  // any pulse in here is one trap too many
  task automatic drop_lines(input string test_name);
    for (int k = 0; k < IDLE_CYCLES; k++)
    begin
      @(posedge clk);
      if (k == 0)
      begin
        irq_i <= '0;
      end
      flush_i      <= (k < DRAIN_CYCLES);
      core_ready_i <= 1'b1;
      @(negedge clk);
      if (trap_valid_o)
      begin
        abort_run($sformatf("ERROR: test %s gave a second trap pulse", test_name));
      end
    end
  endtask

  task automatic run_test(input int t);
    irq_lines_t irq_drv;
    addr_t      mtvec_drv;
    addr_t      exp_vec;
    int         rnd;
    int         cyc;
    int         hold;
    logic       seen;
    // random fill of the disabled lines and of the mtvec low bits
    irq_drv   = irq_mem[t] | (irq_lines_t'($random(seed)) & ~en_mem[t]);
    rnd       = $random(seed);
    mtvec_drv = {mtvec_mem[t][31:8], rnd[7:2], 2'b00};
    exp_vec   = mtvec_drv + addr_t'(id_mem[t]) * IRQ_VEC_STRIDE;
    hold      = (flush_mem[t] > ready_mem[t]) ? flush_mem[t] : ready_mem[t];
    seen      = 1'b0;
    cyc       = 0;
    while (!seen && cyc < WAIT_CYCLES)
    begin
      @(posedge clk);
      if (cyc == 0)
      begin
        irq_i          <= irq_drv;
        irq_en_i       <= en_mem[t];
        irq_sec_mask_i <= sec_mem[t];
        m_ie_i         <= m_ie_mem[t];
        u_ie_i         <= u_ie_mem[t];
        priv_lvl_i     <= priv_mem[t];
        mtvec_i        <= mtvec_drv;
      end
      // higher lines rise during back-pressure while the latched id must stay
      if (cyc == RAISE_CYCLE && flush_mem[t] == 0 && ready_mem[t] > RAISE_CYCLE)
      begin
        irq_i <= irq_drv | en_mem[t];
      end
      flush_i      <= (cyc < flush_mem[t]);
      core_ready_i <= (cyc >= ready_mem[t]);
      @(negedge clk);
      if (trap_valid_o)
      begin
        seen = 1'b1;
        if (!taken_mem[t])
        begin
          abort_run($sformatf("ERROR: test %s took a trap that should be blocked",
                              name_mem[t]));
        end
        else if (cyc <= hold)
        begin
          abort_run($sformatf("ERROR: test %s took a trap during its hold", name_mem[t]));
        end
        else
        begin
          check_id(name_mem[t], id_mem[t], trap_id_o);
          check_bit(name_mem[t], "trap_sec", sec_bit_mem[t], trap_sec_o);
          check_vec(name_mem[t], exp_vec, trap_vec_o);
        end
      end
      cyc++;
    end
    if (taken_mem[t] && !seen)
    begin
      abort_run($sformatf("ERROR: test %s saw no trap within %0d cycles",
                          name_mem[t], WAIT_CYCLES));
    end
    else
    begin
      drop_lines(name_mem[t]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n          = 1'b0;
    irq_i          = '0;
    irq_en_i       = '0;
    irq_sec_mask_i = '0;
    m_ie_i         = 1'b0;
    u_ie_i         = 1'b0;
    priv_lvl_i     = PRIV_LVL_M;
    mtvec_i        = '0;
    core_ready_i   = 1'b1;
    flush_i        = 1'b0;
    seed           = 63174;
    load_tests();
    // no test runs longer than 100 cycles plus the reset
    cycle_limit = num_tests * 100 + 20;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int t = 0; t < num_tests; t++)
    begin
      run_test(t);
    end
    if (num_tests == 0)
    begin
      $display("ERROR: no test line found in irq_testdata.txt");
      $display("Simulation failed");
      $fatal(1);
    end
    else
    begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule
